// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ctrl_pkg.sv
      - verilog/instrDecoder.sv
      - verilog/phaseSequencer.sv
      - verilog/controlEncoder.sv
      - verilog/controlUnit.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/clockGen.sv
      - tests/controlUnit_chk.sv
      - tests/controlUnit_tb.sv

// ==== src.f ====
+incdir+verilog
verilog/ctrl_pkg.sv
verilog/instrDecoder.sv
verilog/phaseSequencer.sv
verilog/controlEncoder.sv
verilog/controlUnit.sv
tests/clockGen.sv
tests/controlUnit_chk.sv
tests/controlUnit_tb.sv

// ==== tests/clockGen.sv ====
`timescale 1ns/10ps

module clockGen (
    output logic clock,
    output logic reset
);
    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Released just after the eighth rising edge
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clock);
        #1 reset = 1'b0;
    end

endmodule

// ==== tests/controlUnit_chk.sv ====
`timescale 1ns/10ps

module controlUnit_chk (
    input logic                   clock,
    input logic                   reset,
    input ctrl_pkg::datapathCtrlT ctrl
);
    import ctrl_pkg::*;

    logic [7:0] enables;

    assign enables = {ctrl.memWrite, ctrl.irWrite, ctrl.regWrite, ctrl.pcWrite,
                      ctrl.regALoad, ctrl.regBLoad, ctrl.aluOutLoad, ctrl.epcWrite};

    irWriteAlone: assert property (@(posedge clock) disable iff (reset)
        ctrl.irWrite |-> !(ctrl.memWrite || ctrl.regWrite))
        else $error("irWrite coincides with a register or memory write");

    // No enable may stay high on two consecutive cycles
    singlePulse: assert property (@(posedge clock) disable iff (reset)
        (enables & $past(enables)) == '0)
        else $error("write enable held longer than one cycle");

    idleAfterReset: assert property (@(posedge clock) reset |=> ctrl == ctrlIdle)
        else $error("control word not idle after reset");

endmodule

bind controlUnit controlUnit_chk chk0 (
    .clock (clock),
    .reset (reset),
    .ctrl  (ctrl)
);

// ==== tests/controlUnit_tb.sv ====
`timescale 1ns/10ps
`include "ctrl_consts.svh"

module controlUnit_tb;
    import ctrl_pkg::*;

    localparam int driveDelay  = 2;
    localparam int maxCycles   = 40;
    localparam int fixedCycles = `CTRL_FETCH_STEPS + `CTRL_DECODE_STEPS;

    logic         clock;
    logic         reset;
    instrFieldsT  instr;
    logic         overflow;
    datapathCtrlT ctrl;

    int           checkCount;
    int           errorCount;
    bit           aborted;
    int           interval;
    int           regWrites;
    int           memWrites;
    int           epcWrites;
    int           pcWrites;
    datapathCtrlT regWord;
    datapathCtrlT memWriteWord;
    datapathCtrlT pcWord;

    clockGen clockGen0 (
        .clock (clock),
        .reset (reset)
    );

    controlUnit dut0 (
        .clock    (clock),
        .reset    (reset),
        .instr    (instr),
        .overflow (overflow),
        .ctrl     (ctrl)
    );

    task automatic verify(input bit cond, input string msg);
        checkCount++;
        assert (cond) else begin
            errorCount++;
            $display("FAIL %0t: %s", $time, msg);
        end
    endtask

    task automatic abortRun(input string what);
        aborted = 1'b1;
        errorCount++;
        $display("Timeout: %s within %0d cycles", what, maxCycles);
    endtask

    function automatic instrFieldsT encodeFields(input logic [7:0] op, input logic [7:0] fn);
        instrFieldsT fields;
        fields.opcode = op[`CTRL_OPCODE_W-1:0];
        fields.funct  = fn[`CTRL_FUNCT_W-1:0];
        return fields;
    endfunction

    task automatic tally(input datapathCtrlT w);
        if (w.regWrite) begin
            regWrites++;
            regWord = w;
        end
        if (w.memWrite) begin
            memWrites++;
            memWriteWord = w;
        end
        if (w.epcWrite) begin
            epcWrites++;
        end
        // Fetch pcWrite rides with irWrite and is not counted
        if (w.pcWrite && !w.irWrite) begin
            pcWrites++;
            pcWord = w;
        end
    endtask

    // Starts in the irWrite cycle, ends in the next one
    task automatic runInstr(input instrFieldsT fields, input logic ovf);
        regWrites    = 0;
        memWrites    = 0;
        epcWrites    = 0;
        pcWrites     = 0;
        regWord      = ctrlIdle;
        memWriteWord = ctrlIdle;
        pcWord       = ctrlIdle;
        @(posedge clock);
        #driveDelay;
        instr    = fields;
        overflow = ovf;
        interval = 1;
        tally(ctrl);
        while (!ctrl.irWrite && interval < maxCycles) begin
            @(posedge clock);
            #driveDelay;
            interval++;
            tally(ctrl);
        end
        if (!ctrl.irWrite) begin
            abortRun("no irWrite for next instruction");
        end else begin
            verify(ctrl.pcWrite, "fetch pcWrite missing with irWrite");
        end
    endtask

    task automatic checkInterval(input string name, input int expected);
        verify(interval == expected, $sformatf("%s: interval %0d, expected %0d",
                                               name, interval, expected));
    endtask

    task automatic checkReset();
        int cycles;
        cycles = 0;
        @(posedge clock);
        #driveDelay;
        while (reset && cycles < maxCycles) begin
            verify(ctrl == ctrlIdle, "ctrl active during reset");
            @(posedge clock);
            #driveDelay;
            cycles++;
        end
        if (reset) begin
            abortRun("reset never released");
            return;
        end
        cycles = 0;
        while (!ctrl.irWrite && cycles < maxCycles) begin
            verify(!ctrl.regWrite && !ctrl.memWrite, "write before first fetch");
            @(posedge clock);
            #driveDelay;
            cycles++;
        end
        if (!ctrl.irWrite) begin
            abortRun("no first irWrite");
            return;
        end
        verify(cycles == `CTRL_FETCH_STEPS + 1,
               $sformatf("first irWrite after %0d cycles", cycles));
    endtask

    task automatic checkAlu(input string name, input logic [7:0] op, input logic [7:0] fn,
                            input logic ovf, input aluOpT expOp, input bit trap);
        bit regForm;
        if (aborted) return;
        regForm = (op == opRType);
        runInstr(encodeFields(op, fn), ovf);
        if (aborted) return;
        if (trap) begin
            verify(regWrites == 0, {name, ": regWrite despite overflow"});
            verify(epcWrites == 1 && pcWord.pcSource == pcException,
                   {name, ": overflow exception missing"});
        end else begin
            verify(regWrites == 1 && epcWrites == 0, {name, ": expected one regWrite"});
            verify(regWord.aluOp == expOp, {name, ": aluOp mismatch"});
            verify(regWord.regDst == (regForm ? dstRd : dstRt), {name, ": regDst mismatch"});
            verify(regWord.aluSrcB == (regForm ? srcBRegB : srcBImm),
                   {name, ": aluSrcB mismatch"});
            checkInterval(name, fixedCycles + 3);
        end
    endtask

    task automatic checkMem(input string name, input logic [7:0] op, input memSizeT size,
                            input bit isStore);
        if (aborted) return;
        runInstr(encodeFields(op, 8'h00), 1'b0);
        if (aborted) return;
        if (isStore) begin
            verify(memWrites == 1 && regWrites == 0, {name, ": expected one memWrite"});
            verify(memWriteWord.storeSize == size, {name, ": storeSize mismatch"});
            checkInterval(name, fixedCycles + 6);
        end else begin
            verify(regWrites == 1 && memWrites == 0, {name, ": expected one regWrite"});
            verify(regWord.loadSize == size, {name, ": loadSize mismatch"});
            checkInterval(name, fixedCycles + 5);
        end
    endtask

    task automatic checkLui();
        if (aborted) return;
        runInstr(encodeFields(opLui, 8'h00), 1'b0);
        if (aborted) return;
        verify(regWrites == 1 && regWord.shiftLoad, "lui: regWrite without shiftLoad");
        checkInterval("lui", fixedCycles + 2);
    endtask

    task automatic checkPcInstr(input string name, input logic [7:0] fn,
                                input pcSourceT expSrc);
        if (aborted) return;
        runInstr(encodeFields(opRType, fn), 1'b0);
        if (aborted) return;
        verify(pcWrites == 1 && pcWord.pcSource == expSrc, {name, ": pcWrite or pcSource"});
        verify(regWrites + memWrites + epcWrites == 0, {name, ": unexpected write"});
        checkInterval(name, fixedCycles + 2);
    endtask

    task automatic checkIllegal(input string name, input instrFieldsT fields);
        if (aborted) return;
        runInstr(fields, 1'b0);
        if (aborted) return;
        verify(epcWrites == 1, {name, ": expected one epcWrite"});
        verify(regWrites == 0 && memWrites == 0, {name, ": write on illegal instruction"});
        checkInterval(name, fixedCycles + 2);
    endtask

    task automatic checkIllegalRandom(input int count);
        logic [7:0] fn;
        for (int i = 0; i < count; i++) begin
            fn = 8'($urandom_range(63, 0));
            // Remap a kept code to an unused one
            if (fn inside {fnBreak, fnRte, fnAdd, fnSub, fnAnd}) begin
                fn = 8'h3F;
            end
            checkIllegal($sformatf("funct %02h", fn), encodeFields(opRType, fn));
        end
    endtask

    initial begin
        void'($urandom(76213));
        instr      = encodeFields(opRType, fnAdd);
        overflow   = 1'b0;
        checkCount = 0;
        errorCount = 0;
        aborted    = 1'b0;

        checkReset();
        checkAlu("add", opRType, fnAdd, 1'b0, aluAdd, 1'b0);
        checkAlu("sub", opRType, fnSub, 1'b0, aluSub, 1'b0);
        checkAlu("and", opRType, fnAnd, 1'b0, aluAnd, 1'b0);
        checkAlu("addi", opAddi, 8'h00, 1'b0, aluAdd, 1'b0);
        checkAlu("addiu", opAddiu, 8'h00, 1'b0, aluAdd, 1'b0);
        checkAlu("add ovf", opRType, fnAdd, 1'b1, aluAdd, 1'b1);
        checkAlu("sub ovf", opRType, fnSub, 1'b1, aluSub, 1'b1);
        checkAlu("addi ovf", opAddi, 8'h00, 1'b1, aluAdd, 1'b1);
        checkAlu("addiu ovf", opAddiu, 8'h00, 1'b1, aluAdd, 1'b0);
        checkMem("lw", opLw, memWord, 1'b0);
        checkMem("lh", opLh, memHalf, 1'b0);
        checkMem("lb", opLb, memByte, 1'b0);
        checkMem("sw", opSw, memWord, 1'b1);
        checkMem("sh", opSh, memHalf, 1'b1);
        checkMem("sb", opSb, memByte, 1'b1);
        checkLui();
        checkPcInstr("break", fnBreak, pcAluResult);
        checkPcInstr("rte", fnRte, pcEpc);
        checkIllegal("opcode 3f", encodeFields(8'h3F, 8'h00));
        checkIllegalRandom(6);

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== verilog/controlEncoder.sv ====
`timescale 1ns/10ps
`include "ctrl_consts.svh"

module controlEncoder (
    input  logic                    clock,
    input  logic                    reset,
    input  ctrl_pkg::phaseT         phase,
    input  logic [`CTRL_STEP_W-1:0] step,
    input  ctrl_pkg::instrClassT    instrClass,
    output ctrl_pkg::datapathCtrlT  ctrl
);
    import ctrl_pkg::*;

    datapathCtrlT word;
    aluOpT        regOp;
    memSizeT      accessSize;
    logic         regForm;

    always_comb begin
        case (instrClass)
            clsSub:  regOp = aluSub;
            clsAnd:  regOp = aluAnd;
            default: regOp = aluAdd;
        endcase
    end

    always_comb begin
        case (instrClass)
            clsLoadWord, clsStoreWord: accessSize = memWord;
            clsLoadHalf, clsStoreHalf: accessSize = memHalf;
            clsLoadByte, clsStoreByte: accessSize = memByte;
            default:                   accessSize = memNone;
        endcase
    end

    assign regForm = instrClass inside {clsAdd, clsSub, clsAnd};

    always_comb begin
        word = ctrlIdle;
        case (phase)
            phFetch: begin
                // PC + 4 computed while memory reads the instruction
                word.aluSrcA  = srcAPc;
                word.aluSrcB  = srcBFour;
                word.aluOp    = aluAdd;
                word.pcSource = pcAluResult;
                word.irWrite  = (step == `CTRL_FETCH_STEPS - 1);
                word.pcWrite  = (step == `CTRL_FETCH_STEPS - 1);
            end
            phDecode: begin
                word.regALoad = (step == 0);
                word.regBLoad = (step == 0);
            end
            phExecute: begin
                case (instrClass)
                    clsAdd, clsSub, clsAnd, clsAddi, clsAddiu: begin
                        word.aluSrcA    = srcARegA;
                        word.aluSrcB    = regForm ? srcBRegB : srcBImm;
                        word.aluOp      = regOp;
                        word.regDst     = regForm ? dstRd : dstRt;
                        word.dataSrc    = dsAluOut;
                        word.aluOutLoad = (step == 0);
                        word.regWrite   = (step == 1);
                    end
                    clsLoadWord, clsLoadHalf, clsLoadByte: begin
                        word.aluSrcA    = srcARegA;
                        word.aluSrcB    = srcBImm;
                        word.aluOp      = aluAdd;
                        word.aluOutLoad = (step == 0);
                        word.iorD       = (step != 0);
                        word.regDst     = dstRt;
                        word.dataSrc    = dsMemData;
                        word.regWrite   = (step == 4);
                        word.loadSize   = (step == 4) ? accessSize : memNone;
                    end
                    clsStoreWord, clsStoreHalf, clsStoreByte: begin
                        word.aluSrcA    = srcARegA;
                        word.aluSrcB    = srcBImm;
                        word.aluOp      = aluAdd;
                        word.aluOutLoad = (step == 0);
                        word.iorD       = (step >= 2);
                        word.memWrite   = (step == 5);
                        word.storeSize  = (step == 5) ? accessSize : memNone;
                    end
                    clsLoadUpper: begin
                        word.regDst    = dstRt;
                        word.dataSrc   = dsShifter;
                        word.regWrite  = (step == 1);
                        word.shiftLoad = (step == 1);
                    end
                    clsBreak: begin
                        // PC back to the break instruction
                        word.aluSrcA  = srcAPc;
                        word.aluSrcB  = srcBFour;
                        word.aluOp    = aluSub;
                        word.pcSource = pcAluResult;
                        word.pcWrite  = (step == 0);
                    end
                    clsReturn: begin
                        word.pcSource = pcEpc;
                        word.pcWrite  = (step == 0);
                    end
                    default: begin
                        word = ctrlIdle;
                    end
                endcase
            end
            phException: begin
                // EPC gets the address of the faulting instruction
                word.aluSrcA  = srcAPc;
                word.aluSrcB  = srcBFour;
                word.aluOp    = aluSub;
                word.epcWrite = 1'b1;
                word.pcSource = pcException;
                word.pcWrite  = 1'b1;
            end
            default: begin
                word = ctrlIdle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ctrl <= ctrlIdle;
        end else begin
            ctrl <= word;
        end
    end

endmodule

// ==== verilog/controlUnit.sv ====
`timescale 1ns/10ps
`include "ctrl_consts.svh"

module controlUnit (
    input  logic                   clock,
    input  logic                   reset,
    input  ctrl_pkg::instrFieldsT  instr,
    input  logic                   overflow,
    output ctrl_pkg::datapathCtrlT ctrl
);
    import ctrl_pkg::*;

    instrClassT              instrClass;
    phaseT                   phase;
    logic [`CTRL_STEP_W-1:0] step;

    instrDecoder decoder0 (
        .instr      (instr),
        .instrClass (instrClass)
    );

    phaseSequencer sequencer0 (
        .clock      (clock),
        .reset      (reset),
        .instrClass (instrClass),
        .overflow   (overflow),
        .phase      (phase),
        .step       (step)
    );

    controlEncoder encoder0 (
        .clock      (clock),
        .reset      (reset),
        .phase      (phase),
        .step       (step),
        .instrClass (instrClass),
        .ctrl       (ctrl)
    );

endmodule

// ==== verilog/ctrl_consts.svh ====
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

// Instruction field widths

// Primary opcode, bits 31..26 of the instruction
`define CTRL_OPCODE_W 6

// R-type function code, bits 5..0
`define CTRL_FUNCT_W 6

// Step counter

// Wide enough for the longest execute sequence (store, 6 cycles)
`define CTRL_STEP_W 3

// Phase lengths in clock cycles

// Memory read of the instruction takes the first two cycles,
// IR and PC are written in the third
`define CTRL_FETCH_STEPS 3

// Register operands are latched in the first decode cycle
`define CTRL_DECODE_STEPS 2

`endif

// ==== verilog/ctrl_pkg.sv ====
`include "ctrl_consts.svh"

package ctrl_pkg;

    typedef enum logic [7:0] {
        opRType = 8'h00,
        opAddi  = 8'h08,
        opAddiu = 8'h09,
        opLui   = 8'h0F,
        opLb    = 8'h20,
        opLh    = 8'h21,
        opLw    = 8'h23,
        opSb    = 8'h28,
        opSh    = 8'h29,
        opSw    = 8'h2B
    } opcodeT;

    typedef enum logic [7:0] {
        fnBreak = 8'h0D,
        fnRte   = 8'h13,
        fnAdd   = 8'h20,
        fnSub   = 8'h22,
        fnAnd   = 8'h24
    } functT;

    // Decoded class, loads and stores carry their access size
    typedef enum logic [3:0] {
        clsAdd, clsSub, clsAnd,
        clsAddi, clsAddiu,
        clsLoadWord, clsLoadHalf, clsLoadByte,
        clsStoreWord, clsStoreHalf, clsStoreByte,
        clsLoadUpper, clsBreak, clsReturn,
        clsIllegal
    } instrClassT;

    typedef enum logic [2:0] {
        phReset, phFetch, phDecode, phExecute, phException
    } phaseT;

    typedef struct packed {
        logic [`CTRL_OPCODE_W-1:0] opcode;
        logic [`CTRL_FUNCT_W-1:0]  funct;
    } instrFieldsT;

    typedef enum logic [2:0] {
        aluAdd = 3'b001,
        aluSub = 3'b010,
        aluAnd = 3'b011
    } aluOpT;

    typedef enum logic [2:0] {
        dsShifter = 3'b011,
        dsAluOut  = 3'b110,
        dsMemData = 3'b111
    } dataSrcT;

    typedef enum logic [1:0] {dstRt = 2'b01, dstRd = 2'b11} regDstT;

    // pcException loads the handler address
    typedef enum logic [1:0] {
        pcAluResult = 2'b01, pcException = 2'b10, pcEpc = 2'b11
    } pcSourceT;

    typedef enum logic [1:0] {srcAPc = 2'b01, srcARegA = 2'b10} aluSrcAT;

    typedef enum logic [1:0] {
        srcBImm = 2'b00, srcBFour = 2'b01, srcBRegB = 2'b10
    } aluSrcBT;

    typedef enum logic [1:0] {
        memNone = 2'b00, memWord = 2'b01, memByte = 2'b10, memHalf = 2'b11
    } memSizeT;

    typedef struct packed {
        logic     memWrite;
        logic     irWrite;
        logic     regWrite;
        logic     pcWrite;
        logic     regALoad;
        logic     regBLoad;
        logic     aluOutLoad;
        logic     epcWrite;
        aluOpT    aluOp;
        aluSrcAT  aluSrcA;
        aluSrcBT  aluSrcB;
        pcSourceT pcSource;
        logic     iorD;      // 0 addresses memory with PC, 1 with ALUOut
        regDstT   regDst;
        dataSrcT  dataSrc;
        memSizeT  storeSize;
        memSizeT  loadSize;
        logic     shiftLoad;
    } datapathCtrlT;

    localparam datapathCtrlT ctrlIdle = datapathCtrlT'('0);

endpackage

// ==== verilog/instrDecoder.sv ====
`timescale 1ns/10ps
`include "ctrl_consts.svh"

module instrDecoder (
    input  ctrl_pkg::instrFieldsT instr,
    output ctrl_pkg::instrClassT  instrClass
);
    import ctrl_pkg::*;

    opcodeT opcode;
    functT  funct;

    // Fields widened to the byte-wide code enums
    assign opcode = opcodeT'({{($bits(opcodeT) - `CTRL_OPCODE_W){1'b0}}, instr.opcode});
    assign funct  = functT'({{($bits(functT) - `CTRL_FUNCT_W){1'b0}}, instr.funct});

    always_comb begin
        case (opcode)
            opRType: begin
                case (funct)
                    fnAdd:   instrClass = clsAdd;
                    fnSub:   instrClass = clsSub;
                    fnAnd:   instrClass = clsAnd;
                    fnBreak: instrClass = clsBreak;
                    fnRte:   instrClass = clsReturn;
                    default: instrClass = clsIllegal;
                endcase
            end
            opAddi: begin
                instrClass = clsAddi;
            end
            opAddiu: begin
                instrClass = clsAddiu;
            end
            opLw: begin
                instrClass = clsLoadWord;
            end
            opLh: begin
                instrClass = clsLoadHalf;
            end
            opLb: begin
                instrClass = clsLoadByte;
            end
            opSw: begin
                instrClass = clsStoreWord;
            end
            opSh: begin
                instrClass = clsStoreHalf;
            end
            opSb: begin
                instrClass = clsStoreByte;
            end
            opLui: begin
                instrClass = clsLoadUpper;
            end
            default: begin
                instrClass = clsIllegal;
            end
        endcase
    end

endmodule

// ==== verilog/phaseSequencer.sv ====
`timescale 1ns/10ps
`include "ctrl_consts.svh"

module phaseSequencer (
    input  logic                    clock,
    input  logic                    reset,
    input  ctrl_pkg::instrClassT    instrClass,
    input  logic                    overflow,
    output ctrl_pkg::phaseT         phase,
    output logic [`CTRL_STEP_W-1:0] step
);
    import ctrl_pkg::*;

    phaseT                   phaseReg;
    phaseT                   phaseNext;
    logic [`CTRL_STEP_W-1:0] stepNext;
    logic [`CTRL_STEP_W-1:0] lastStep;
    logic                    overflowTrap;

    // Last step index of each execute sequence
    function automatic logic [`CTRL_STEP_W-1:0] executeLast(instrClassT cls);
        case (cls)
            clsAdd, clsSub, clsAnd, clsAddi, clsAddiu: begin
                return 2;
            end
            clsLoadWord, clsLoadHalf, clsLoadByte: begin
                return 4;
            end
            clsStoreWord, clsStoreHalf, clsStoreByte: begin
                return 5;
            end
            clsLoadUpper, clsBreak, clsReturn: begin
                return 1;
            end
            default: begin
                return 0;
            end
        endcase
    endfunction

    always_comb begin
        case (phaseReg)
            phFetch:   lastStep = `CTRL_FETCH_STEPS - 1;
            phDecode:  lastStep = `CTRL_DECODE_STEPS - 1;
            phExecute: lastStep = executeLast(instrClass);
            default:   lastStep = '0;
        endcase
    end

    // addiu and the logical op never trap
    assign overflowTrap = (phaseReg == phExecute) && (step == 1) && overflow
                          && (instrClass inside {clsAdd, clsSub, clsAddi});

    always_comb begin
        phaseNext = phaseReg;
        stepNext  = step + 1'b1;
        if (overflowTrap) begin
            // Exception cycle replaces step 1, fetch follows
            phaseNext = phFetch;
            stepNext  = '0;
        end else if (phaseReg == phReset || step == lastStep) begin
            stepNext = '0;
            case (phaseReg)
                phReset:   phaseNext = phFetch;
                phFetch:   phaseNext = phDecode;
                phDecode:  phaseNext = phExecute;
                phExecute: phaseNext = (instrClass == clsIllegal) ? phException : phFetch;
                default:   phaseNext = phFetch;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            phaseReg <= phReset;
            step     <= '0;
        end else begin
            phaseReg <= phaseNext;
            step     <= stepNext;
        end
    end

    // Encoder sees the trap in the same cycle it is detected
    assign phase = overflowTrap ? phException : phaseReg;

endmodule
